// File: files.f
rtl/issue_pkg.sv
rtl/slot_decode.sv
rtl/issue_bank.sv
rtl/pair_check.sv
rtl/issue_ctrl.sv
rtl/issue_stage.sv
tb/tb_clock.sv
tb/issue_stage_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := issue_stage_tb
FILELIST := files.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := Done: no errors
FAIL_MSG := Done: errors found
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/issue_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage_tb;

  localparam int depth         = 8;
  localparam int p1_pairs      = 24;
  localparam int p2_pairs      = 160;
  localparam int hold_rounds   = 3;
  localparam int hold_cycles   = depth + 6;
  localparam int clear_rounds  = 4;
  localparam int drain_cycles  = 2 * depth + 4;
  localparam int stim_cycles   = 16 + p1_pairs + 2 * p2_pairs +
                                 hold_rounds * (hold_cycles + 2 * depth + 3) +
                                 clear_rounds * 12 + drain_cycles;
  localparam int timeout_cycles = stim_cycles * 4 + 200;

  logic        clock;
  logic        reset;
  logic        in_valid;
  logic [31:0] in_pc;
  logic [31:0] in_word0;
  logic [31:0] in_word1;
  logic        hold;
  logic        clear;
  logic        stall;
  logic        out_valid0;
  logic [31:0] out_pc0;
  logic [31:0] out_word0;
  logic        out_valid1;
  logic [31:0] out_pc1;
  logic [31:0] out_word1;

  logic [31:0] ref_pc[$];
  logic [31:0] ref_word[$];
  logic [31:0] next_pc     = 32'h0000_1000;
  logic [31:0] last_pc     = '0;
  logic [31:0] clear_floor = '0;
  logic [31:0] lfsr_state  = 32'hc4a6;
  int          reset_edges = 0;
  bit          reset_checked = 1'b0;
  int          value_errors = 0;
  int          rule_errors = 0;
  int          flow_errors = 0;
  int          assert_errors = 0;

  tb_clock #(.period(20), .reset_cycles(16)) u_tb_clock (.clock(clock), .reset(reset));

  issue_stage #(.depth(depth)) u_issue_stage (
    .clock(clock), .reset(reset), .in_valid(in_valid), .in_pc(in_pc),
    .in_word0(in_word0), .in_word1(in_word1), .hold(hold), .clear(clear), .stall(stall),
    .out_valid0(out_valid0), .out_pc0(out_pc0), .out_word0(out_word0),
    .out_valid1(out_valid1), .out_pc1(out_pc1), .out_word1(out_word1)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return value;
  endfunction

  // Registers come from x0..x7 so that dependences are frequent.
  function automatic logic [31:0] random_word();
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    kind = 4'(random_bits(4));
    rd   = 5'(random_bits(3));
    rs1  = 5'(random_bits(3));
    rs2  = 5'(random_bits(3));
    f3   = 3'(random_bits(3));
    imm  = {7'd0, 5'(random_bits(5))};
    case (kind)
      4'd0, 4'd1, 4'd2, 4'd3: return {7'd0, rs2, rs1, f3, rd, 7'b0110011};
      4'd4, 4'd5: return {imm, rs1, f3, rd, 7'b0010011};
      4'd6: return {imm, rs1, 3'b010, rd, 7'b0000011};
      4'd7: return {7'd0, rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
      4'd8: return {7'd0, rs2, rs1, f3[2], f3[2] & f3[1], f3[0], imm[4:1], 1'b0, 7'b1100011};
      4'd9: return {7'd1, rs2, rs1, 1'b0, f3[1:0], rd, 7'b0110011};
      4'd10: return {7'd1, rs2, rs1, 1'b1, f3[1:0], rd, 7'b0110011};
      4'd11: return {12'h340, rs1, f3[2], (f3[1:0] == 2'd0) ? 2'd1 : f3[1:0], rd, 7'b1110011};
      4'd12: return (f3[1:0] == 2'd0) ? 32'h0000_0073 :
                    (f3[1:0] == 2'd1) ? 32'h0010_0073 : 32'h0ff0_000f;
      4'd13: return {imm, rs1, f3, rd, 7'b0110111};
      4'd14: return {imm, rs1, f3, rd, 7'b1101111};
      default: return {imm, rs1, 3'b000, rd, 7'b1100111};
    endcase
  endfunction

  // Unit that a word needs alone: 1 mul, 2 div, 3 csr, 0 none.
  function automatic logic [1:0] unit_of(input logic [31:0] w);
    if (w[6:0] == 7'b0110011 && w[31:25] == 7'd1) return w[14] ? 2'd2 : 2'd1;
    return (w[6:0] == 7'b1110011 && w[14:12] != 3'd0) ? 2'd3 : 2'd0;
  endfunction

  function automatic logic breaks_pair(input logic [31:0] a, input logic [31:0] b);
    logic       serial;
    logic [4:0] dest;
    logic       src1;
    logic       src2;
    serial = (a[6:0] == 7'b0001111) || (b[6:0] == 7'b0001111) ||
             (a[6:0] == 7'b1110011 && a[14:12] == 3'd0) ||
             (b[6:0] == 7'b1110011 && b[14:12] == 3'd0);
    dest = ((a[6:0] inside {7'b0100011, 7'b1100011, 7'b0001111}) ||
            (a[6:0] == 7'b1110011 && a[14:12] == 3'd0)) ? 5'd0 : a[11:7];
    src1 = (b[6:0] inside {7'b0110011, 7'b1100011, 7'b0100011, 7'b0010011, 7'b0000011,
                           7'b1100111}) || (b[6:0] == 7'b1110011 && b[14:12] != 3'd0 && !b[14]);
    src2 = b[6:0] inside {7'b0110011, 7'b1100011, 7'b0100011};
    return serial || (unit_of(a) != 2'd0 && unit_of(a) == unit_of(b)) ||
           (dest != 5'd0 && ((src1 && b[19:15] == dest) || (src2 && b[24:20] == dest)));
  endfunction

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    assert (got === expected) else begin
      value_errors++;
      $display("FAILED %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic retire(input string slot, input logic [31:0] pc, input logic [31:0] word);
    assert (ref_pc.size() != 0) else begin
      rule_errors++;
      $display("Slot %s issued pc %h with no pending record", slot, pc);
    end
    if (ref_pc.size() != 0) begin
      expect_value({"out_pc", slot}, pc, ref_pc.pop_front());
      expect_value({"out_word", slot}, word, ref_word.pop_front());
    end
    assert (pc >= clear_floor) else begin
      rule_errors++;
      $display("Slot %s issued pc %h that was pushed before a clear", slot, pc);
    end
  endtask

  always @(posedge clock) begin
    if (!reset) begin
      reset_edges++;
      if (reset_edges > 1) begin  // Registers are unknown before the first edge.
        expect_value("stall", 32'(stall), 32'd0);
        expect_value("out_valid0", 32'(out_valid0), 32'd0);
        expect_value("out_valid1", 32'(out_valid1), 32'd0);
      end
    end else begin
      if (!reset_checked) begin
        expect_value("stall", 32'(stall), 32'd0);
        expect_value("out_valid0", 32'(out_valid0), 32'd0);
        expect_value("out_valid1", 32'(out_valid1), 32'd0);
        reset_checked = 1'b1;
      end
      if (in_valid && !stall && !clear) begin
        ref_pc.push_back(in_pc);
        ref_word.push_back(in_word0);
        ref_pc.push_back(in_pc + 32'd4);
        ref_word.push_back(in_word1);
        last_pc = in_pc + 32'd4;
      end
      if (!hold && !out_valid0 && !out_valid1) begin
        assert (ref_pc.size() == 0) else begin
          rule_errors++;
          $display("Nothing issued while %0d records were pending", ref_pc.size());
        end
      end
      if (out_valid0) retire("0", out_pc0, out_word0);
      if (out_valid1) retire("1", out_pc1, out_word1);
      if (out_valid0 && out_valid1) begin
        assert (!breaks_pair(out_word0, out_word1)) else begin
          rule_errors++;
          $display("Words %h and %h issued together against the pairing rules",
                   out_word0, out_word1);
        end
      end
      if (out_valid0 && !out_valid1 && !hold) begin
        assert (ref_word.size() == 0 || breaks_pair(out_word0, ref_word[0])) else begin
          rule_errors++;
          $display("Word %h issued alone although %h could pair with it",
                   out_word0, ref_word[0]);
        end
      end
      if (clear) begin
        ref_pc.delete();
        ref_word.delete();
        clear_floor = last_pc + 32'd4;
      end
    end
  end

  no_issue_on_hold: assert property (@(posedge clock) disable iff (!reset)
    hold |-> !(out_valid0 || out_valid1))
    else begin
      assert_errors++;
      $display("Records issued while hold was high");
    end

  slot_order: assert property (@(posedge clock) disable iff (!reset)
    out_valid1 |-> out_valid0)
    else begin
      assert_errors++;
      $display("Slot 1 issued without slot 0");
    end

  task automatic drive_pair(input logic [31:0] word0, input logic [31:0] word1);
    in_valid = 1'b1;
    in_pc    = next_pc;
    in_word0 = word0;
    in_word1 = word1;
  endtask

  // Returns once the pair is sure to be taken at the coming rising edge.
  task automatic push_pair(input logic [31:0] word0, input logic [31:0] word1,
                           input logic hold_level);
    @(negedge clock);
    hold  = hold_level;
    clear = 1'b0;
    drive_pair(word0, word1);
    while (stall) begin
      @(negedge clock);
      hold = 1'b0;
    end
    next_pc += 32'd8;
  endtask

  task automatic idle_cycles(input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      in_valid = 1'b0;
      hold     = 1'b0;
      clear    = 1'b0;
    end
  endtask

  task automatic hold_burst();
    logic [31:0] w0;
    logic [31:0] w1;
    logic        pending;
    logic        stalled_offer;
    int          waited;
    pending       = 1'b0;
    stalled_offer = 1'b0;
    for (int k = 0; k < hold_cycles; k++) begin
      @(negedge clock);
      hold = 1'b1;
      if (!pending) begin
        w0 = random_word();
        w1 = random_word();
        drive_pair(w0, w1);
      end
      pending = stall;  // A refused pair stays on the inputs.
      if (stall) stalled_offer = 1'b1;
      else next_pc += 32'd8;
    end
    @(negedge clock);
    hold = 1'b0;
    if (!pending) in_valid = 1'b0;
    waited = 0;
    while (stall && waited < 2 * depth) begin
      @(negedge clock);
      waited++;
    end
    if (pending) next_pc += 32'd8;
    assert (stalled_offer) else begin
      flow_errors++;
      $display("Stall did not rise during a hold period");
    end
    assert (!stall) else begin
      flow_errors++;
      $display("Stall stayed high after hold was released");
    end
  endtask

  task automatic clear_burst();
    logic [31:0] w0;
    logic [31:0] w1;
    for (int k = 0; k < 3; k++) begin
      w0 = random_word();
      w1 = random_word();
      push_pair(w0, w1, k < 2);
    end
    w0 = random_word();
    w1 = random_word();
    @(negedge clock);
    hold  = 1'b0;
    clear = 1'b1;
    drive_pair(w0, w1);  // This pair is dropped by the flush.
    next_pc += 32'h100;
    idle_cycles(2);
  endtask

  initial begin
    logic [31:0] w0;
    logic [31:0] w1;
    logic        hold_level;
    in_valid = 1'b0;
    in_pc    = '0;
    in_word0 = '0;
    in_word1 = '0;
    hold     = 1'b0;
    clear    = 1'b0;
    wait (reset === 1'b1);
    @(posedge clock);
    for (int k = 0; k < p1_pairs; k++) begin
      w0 = {7'd0, 5'((k + 3) % 16), 5'(k % 16), 3'b000, 5'(16 + k % 16), 7'b0110011};
      w1 = {7'd0, 5'((k + 5) % 16), 5'((k + 1) % 16), 3'b000, 5'(16 + (k + 8) % 16),
            7'b0110011};
      push_pair(w0, w1, 1'b0);
    end
    for (int k = 0; k < p2_pairs; k++) begin
      w0 = random_word();
      w1 = random_word();
      hold_level = (random_bits(3) == 32'd0);
      push_pair(w0, w1, hold_level);
      if (random_bits(2) == 32'd0) idle_cycles(1);
    end
    repeat (hold_rounds) begin
      hold_burst();
      idle_cycles(2);
    end
    repeat (clear_rounds) begin
      w0 = random_word();
      w1 = random_word();
      push_pair(w0, w1, 1'b0);
      clear_burst();
    end
    idle_cycles(drain_cycles);
    assert (ref_pc.size() == 0) else begin
      flow_errors++;
      $display("%0d records were never issued", ref_pc.size());
    end
    $display("Error counts: value %0d, rule %0d, flow %0d, assertion %0d",
             value_errors, rule_errors, flow_errors, assert_errors);
    if (value_errors + rule_errors + flow_errors + assert_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clock);
    $display("Watchdog expired after %0d cycles before the stimulus finished", timeout_cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period       = 20,
  parameter int reset_cycles = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b1;  // Released on a falling edge like the other inputs.
  end

endmodule

`default_nettype wire

// File: rtl/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage #(
  parameter int depth = 8
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        in_valid,
  input  logic [31:0] in_pc,
  input  logic [31:0] in_word0,
  input  logic [31:0] in_word1,
  input  logic        hold,
  input  logic        clear,
  output logic        stall,
  output logic        out_valid0,
  output logic [31:0] out_pc0,
  output logic [31:0] out_word0,
  output logic        out_valid1,
  output logic [31:0] out_pc1,
  output logic [31:0] out_word1
);
  import issue_pkg::*;

  instr_t                   dec0;
  instr_t                   dec1;
  instr_t                   wdata0;
  instr_t                   wdata1;
  instr_t                   rd_data0;
  instr_t                   rd_data1;
  instr_t                   head0;
  instr_t                   head1;
  logic                     wen;
  logic [$clog2(depth)-1:0] waddr;
  logic [$clog2(depth)-1:0] rd_idx0;
  logic [$clog2(depth)-1:0] rd_idx1;
  logic                     pair_ok;

  slot_decode #(.slot(0)) u_decode0 (.valid(in_valid), .pc(in_pc), .word(in_word0), .instr(dec0));

  slot_decode #(.slot(1)) u_decode1 (.valid(in_valid), .pc(in_pc), .word(in_word1), .instr(dec1));

  issue_bank #(.depth(depth)) u_issue_bank (
    .clock(clock), .wen(wen), .waddr(waddr), .wdata0(wdata0), .wdata1(wdata1),
    .raddr0(rd_idx0), .raddr1(rd_idx1), .rdata0(rd_data0), .rdata1(rd_data1)
  );

  pair_check u_pair_check (.first(head0), .second(head1), .pair_ok(pair_ok));

  issue_ctrl #(.depth(depth)) u_issue_ctrl (
    .clock(clock), .reset(reset), .in_valid(in_valid), .clear(clear), .hold(hold),
    .dec0(dec0), .dec1(dec1), .rd_data0(rd_data0), .rd_data1(rd_data1), .pair_ok(pair_ok),
    .wen(wen), .waddr(waddr), .rd_idx0(rd_idx0), .rd_idx1(rd_idx1),
    .wdata0(wdata0), .wdata1(wdata1), .head0(head0), .head1(head1), .stall(stall),
    .out_valid0(out_valid0), .out_pc0(out_pc0), .out_word0(out_word0),
    .out_valid1(out_valid1), .out_pc1(out_pc1), .out_word1(out_word1)
  );

endmodule

`default_nettype wire

// File: rtl/issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl #(
  parameter int depth = 8
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     in_valid,
  input  logic                     clear,
  input  logic                     hold,
  input  issue_pkg::instr_t        dec0,
  input  issue_pkg::instr_t        dec1,
  input  issue_pkg::instr_t        rd_data0,
  input  issue_pkg::instr_t        rd_data1,
  input  logic                     pair_ok,
  output logic                     wen,
  output logic [$clog2(depth)-1:0] waddr,
  output logic [$clog2(depth)-1:0] rd_idx0,
  output logic [$clog2(depth)-1:0] rd_idx1,
  output issue_pkg::instr_t        wdata0,
  output issue_pkg::instr_t        wdata1,
  output issue_pkg::instr_t        head0,
  output issue_pkg::instr_t        head1,
  output logic                     stall,
  output logic                     out_valid0,
  output logic [31:0]              out_pc0,
  output logic [31:0]              out_word0,
  output logic                     out_valid1,
  output logic [31:0]              out_pc1,
  output logic [31:0]              out_word1
);
  import issue_pkg::*;

  localparam int index_width = $clog2(depth);
  localparam int count_width = index_width + 2;
  localparam logic [count_width-1:0] stall_level = count_width'(2 * depth - 2);

  logic [index_width-1:0] wr_ptr;     // Pair units.
  logic [index_width:0]   rd_ptr;     // Slot units, bit 0 is the bank alignment.
  logic [count_width-1:0] count;
  logic [count_width-1:0] avail;
  logic [count_width-1:0] count_next;
  logic [index_width-1:0] rd_entry;
  logic                   push;
  logic [1:0]             issue_count;

  assign push   = in_valid && !stall && !clear;
  assign wen    = push;
  assign waddr  = wr_ptr;
  assign wdata0 = dec0;
  assign wdata1 = dec1;

  assign rd_entry = rd_ptr[index_width:1];
  assign avail    = push ? count + count_width'(2) : count;

  // The pointers keep count and rd_ptr of equal parity, so an empty buffer
  // always has an even head and a single stored slot always an odd one.
  always_comb begin
    if (!rd_ptr[0]) begin
      rd_idx0 = rd_entry;
      rd_idx1 = rd_entry;
      if (count == '0) begin
        head0 = dec0;  // Bypass of the pair offered this cycle.
        head1 = dec1;
      end else begin
        head0 = rd_data0;
        head1 = rd_data1;
      end
    end else begin
      rd_idx0 = rd_entry + 1'b1;
      rd_idx1 = rd_entry;
      head0   = rd_data1;
      head1   = (count == count_width'(1)) ? dec0 : rd_data0;
    end
  end

  always_comb begin
    if (hold || (avail == '0)) begin
      issue_count = 2'd0;
    end else if ((avail == count_width'(1)) || !pair_ok) begin
      issue_count = 2'd1;
    end else begin
      issue_count = 2'd2;
    end
  end

  assign count_next = avail - count_width'(issue_count);

  assign out_valid0 = (issue_count != 2'd0) && head0.valid;
  assign out_pc0    = (issue_count != 2'd0) ? head0.pc : '0;
  assign out_word0  = (issue_count != 2'd0) ? head0.word : '0;
  assign out_valid1 = (issue_count == 2'd2) && head1.valid;
  assign out_pc1    = (issue_count == 2'd2) ? head1.pc : '0;
  assign out_word1  = (issue_count == 2'd2) ? head1.word : '0;

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      stall  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr + (index_width + 1)'(issue_count);
      count  <= count_next;
      stall  <= count_next > stall_level;  // Leaves room for the pair in flight.
    end
  end

  occupancy_bound: assert property (@(posedge clock) disable iff (!reset)
    count <= count_width'(2 * depth))
    else $error("issue_ctrl: occupancy %0d above capacity", count);

  // A write must land on a whole free entry.
  no_write_in_stall: assert property (@(posedge clock) disable iff (!reset)
    wen |-> (count <= stall_level))
    else $error("issue_ctrl: bank written with %0d slots occupied", count);

  in_order_slots: assert property (@(posedge clock) disable iff (!reset)
    out_valid1 |-> (out_valid0 ||
                    !(out_word0[6:0] inside {opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch,
                                             opc_load, opc_store, opc_op_imm, opc_op,
                                             opc_fence, opc_system})))
    else $error("issue_ctrl: slot 1 issued ahead of slot 0");

endmodule

`default_nettype wire

// File: rtl/pair_check.sv
`timescale 1ns/1ps
`default_nettype none

module pair_check (
  input  issue_pkg::instr_t first,
  input  issue_pkg::instr_t second,
  output logic              pair_ok
);
  import issue_pkg::*;

  logic raw;
  logic exclusive;
  logic first_writes;
  logic second_reads1;
  logic second_reads2;
  logic reads_rd;

  // The second record may not consume a result produced in the same cycle.
  assign raw = (second.rden1 && writes_to(first, second.rs1)) ||
               (second.rden2 && writes_to(first, second.rs2));

  assign exclusive = exclusive_pair(first, second);

  assign pair_ok = !raw && !exclusive;

  // Register use taken from the opcode of each word, not from the decoded flags.
  assign first_writes = first.valid && (first.word[11:7] != 5'd0) &&
                        !(first.word[6:0] inside {opc_branch, opc_store, opc_fence}) &&
                        !((first.word[6:0] == opc_system) && (first.word[14:12] == 3'b000));

  assign second_reads1 = (second.word[6:0] inside {opc_jalr, opc_branch, opc_load, opc_store,
                                                   opc_op_imm, opc_op}) ||
                         ((second.word[6:0] == opc_system) &&
                          (second.word[14:12] != 3'b000) && !second.word[14]);

  assign second_reads2 = second.word[6:0] inside {opc_branch, opc_store, opc_op};

  assign reads_rd = second.valid &&
                    ((second_reads1 && (second.word[19:15] == first.word[11:7])) ||
                     (second_reads2 && (second.word[24:20] == first.word[11:7])));

  always_comb begin
    if (first_writes) begin
      assert (!(pair_ok && reads_rd))
        else $error("pair_check: pc %h reads x%0d written by pc %h",
                    second.pc, first.word[11:7], first.pc);
    end
  end

endmodule

`default_nettype wire

// File: rtl/issue_bank.sv
`timescale 1ns/1ps
`default_nettype none

module issue_bank #(
  parameter int depth = 8
) (
  input  logic                     clock,
  input  logic                     wen,
  input  logic [$clog2(depth)-1:0] waddr,
  input  issue_pkg::instr_t        wdata0,
  input  issue_pkg::instr_t        wdata1,
  input  logic [$clog2(depth)-1:0] raddr0,
  input  logic [$clog2(depth)-1:0] raddr1,
  output issue_pkg::instr_t        rdata0,
  output issue_pkg::instr_t        rdata1
);
  import issue_pkg::*;

  // Bank 0 holds the lower slot of each pair, bank 1 the upper slot.
  instr_t bank0 [depth];
  instr_t bank1 [depth];

  always_ff @(posedge clock) begin
    if (wen) begin
      bank0[waddr] <= wdata0;
      bank1[waddr] <= wdata1;
    end
  end

  // Each bank has its own read index so that an odd head can span two entries.
  assign rdata0 = bank0[raddr0];
  assign rdata1 = bank1[raddr1];

endmodule

`default_nettype wire

// File: rtl/slot_decode.sv
`timescale 1ns/1ps
`default_nettype none

module slot_decode #(
  parameter int slot = 0
) (
  input  logic              valid,
  input  logic [31:0]       pc,
  input  logic [31:0]       word,
  output issue_pkg::instr_t instr
);
  import issue_pkg::*;

  opcode_t    major;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       known;

  assign major  = opcode_t'(word[6:0]);
  assign funct3 = word[14:12];
  assign funct7 = word[31:25];

  always_comb begin
    instr      = instr_none;
    known      = 1'b1;
    instr.pc   = pc + 32'(4 * slot);  // The upper slot sits one word above the fetch pc.
    instr.word = word;
    instr.rd   = word[11:7];
    instr.rs1  = word[19:15];
    instr.rs2  = word[24:20];
    case (major)
      opc_lui, opc_auipc: begin
        instr.wren = 1'b1;
      end
      opc_jal: begin
        instr.op_class = op_branch;
        instr.wren     = 1'b1;  // Link register.
      end
      opc_jalr: begin
        instr.op_class = op_branch;
        instr.wren     = 1'b1;
        instr.rden1    = 1'b1;
      end
      opc_branch: begin
        instr.op_class = op_branch;
        instr.rden1    = 1'b1;
        instr.rden2    = 1'b1;
      end
      opc_load: begin
        instr.op_class = op_load;
        instr.wren     = 1'b1;
        instr.rden1    = 1'b1;
      end
      opc_store: begin
        instr.op_class = op_store;
        instr.rden1    = 1'b1;
        instr.rden2    = 1'b1;
      end
      opc_op_imm: begin
        instr.wren  = 1'b1;
        instr.rden1 = 1'b1;
      end
      opc_op: begin
        if (funct7 == 7'b0000001) begin
          instr.op_class = funct3[2] ? op_div : op_mul;  // The M extension.
        end
        instr.wren  = 1'b1;
        instr.rden1 = 1'b1;
        instr.rden2 = 1'b1;
      end
      opc_fence: begin
        instr.op_class = op_system;
      end
      opc_system: begin
        if (funct3 != 3'b000) begin
          instr.op_class = op_csr;
          instr.wren     = 1'b1;
          instr.rden1    = !funct3[2];  // Immediate forms carry a zimm, not rs1.
        end else begin
          instr.op_class = op_system;
        end
      end
      default: begin
        known = 1'b0;
      end
    endcase
    if (instr.rd == 5'd0) begin
      instr.wren = 1'b0;
    end
    instr.valid = valid && known;
  end

endmodule

`default_nettype wire

// File: rtl/issue_pkg.sv
`default_nettype none

package issue_pkg;

  typedef enum logic [2:0] {
    op_alu    = 3'd0,
    op_branch = 3'd1,
    op_load   = 3'd2,
    op_store  = 3'd3,
    op_mul    = 3'd4,
    op_div    = 3'd5,
    op_csr    = 3'd6,
    op_system = 3'd7
  } op_class_t;

  // RV32IM major opcodes, bits [6:0] of the word.
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_fence  = 7'b0001111,
    opc_system = 7'b1110011
  } opcode_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] word;
    op_class_t   op_class;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        wren;
    logic        rden1;
    logic        rden2;
  } instr_t;

  localparam instr_t instr_none = '0;

  // True when the producer updates the given integer register.
  function automatic logic writes_to(input instr_t producer, input logic [4:0] index);
    return producer.valid && producer.wren && (producer.rd == index) && (index != 5'd0);
  endfunction

  // Classes that share a single unit, or that serialize the pipe, cannot pair.
  function automatic logic exclusive_pair(input instr_t first, input instr_t second);
    logic serial;
    logic shared;
    serial = (first.op_class == op_system) || (second.op_class == op_system);
    shared = (first.op_class == second.op_class) &&
             (first.op_class inside {op_mul, op_div, op_csr});
    return serial || shared;
  endfunction

endpackage

`default_nettype wire
